// ==== arbiter.sv ====
`default_nettype none

module arbiter #(
    parameter int PORTS                 = 4,
    parameter bit ARB_TYPE_ROUND_ROBIN  = 1'b0,  // Rotating mask when set.
    parameter bit ARB_BLOCK             = 1'b0,  // Hold the grant once given.
    parameter bit ARB_BLOCK_ACK         = 1'b1,  // Release on ack, else on request drop.
    parameter bit ARB_LSB_HIGH_PRIORITY = 1'b0
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire [PORTS-1:0]          request,
    input  wire [PORTS-1:0]          acknowledge,
    output logic [PORTS-1:0]         grant,
    output logic                     grant_valid,
    output logic [$clog2(PORTS)-1:0] grant_encoded
);

    localparam int IDX_W = $clog2(PORTS);

    logic [PORTS-1:0] grant_d;
    logic             grant_valid_d;
    logic [IDX_W-1:0] grant_encoded_d;
    logic [PORTS-1:0] mask_q;         // Requests eligible before wrapping.
    logic [PORTS-1:0] mask_d;
    logic             hold;

    logic             req_valid;
    logic [IDX_W-1:0] req_idx;
    logic [PORTS-1:0] req_onehot;
    logic             msk_valid;
    logic [IDX_W-1:0] msk_idx;
    logic [PORTS-1:0] msk_onehot;

    priority_encoder #(
        .WIDTH            (PORTS),
        .LSB_HIGH_PRIORITY(ARB_LSB_HIGH_PRIORITY)
    ) u_enc_plain (
        .input_unencoded (request),
        .output_valid    (req_valid),
        .output_encoded  (req_idx),
        .output_unencoded(req_onehot)
    );

    priority_encoder #(
        .WIDTH            (PORTS),
        .LSB_HIGH_PRIORITY(ARB_LSB_HIGH_PRIORITY)
    ) u_enc_masked (
        .input_unencoded (request & mask_q),
        .output_valid    (msk_valid),
        .output_encoded  (msk_idx),
        .output_unencoded(msk_onehot)
    );

    // Blocking keeps the current grant until release.
    assign hold = ARB_BLOCK && (ARB_BLOCK_ACK ? (grant_valid && !(|(grant & acknowledge)))
                                              : (|(grant & request)));

    ////////////////////////////////////////////////////////////////////////////
    // Next grant

    always_comb begin
        grant_d         = '0;
        grant_valid_d   = 1'b0;
        grant_encoded_d = '0;
        mask_d          = mask_q;
        if (hold) begin
            grant_d         = grant;
            grant_valid_d   = grant_valid;
            grant_encoded_d = grant_encoded;
        end else if (req_valid) begin
            grant_valid_d = 1'b1;
            if (ARB_TYPE_ROUND_ROBIN && msk_valid) begin
                grant_d         = msk_onehot;  // Next requester past the last winner.
                grant_encoded_d = msk_idx;
            end else begin
                grant_d         = req_onehot;  // Wrap to the top priority.
                grant_encoded_d = req_idx;
            end
            if (ARB_TYPE_ROUND_ROBIN) begin
                if (ARB_LSB_HIGH_PRIORITY) begin
                    mask_d = {PORTS{1'b1}} << (grant_encoded_d + 1);
                end else begin
                    mask_d = {PORTS{1'b1}} >> (PORTS - grant_encoded_d);  // Bits below.
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant         <= '0;
            grant_valid   <= 1'b0;
            grant_encoded <= '0;
            mask_q        <= '0;
        end else begin
            grant         <= grant_d;
            grant_valid   <= grant_valid_d;
            grant_encoded <= grant_encoded_d;
            mask_q        <= mask_d;
        end
    end

    a_grant_shape: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant) && (grant_valid == (|grant)));

endmodule

`default_nettype wire

// ==== burst_gather.sv ====
`default_nettype none

module burst_gather #(
    parameter int PORTS = 4
) (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire [PORTS-1:0]                       src_req,
    input  wire [PORTS*ether_arb_pkg::LEN_W-1:0]  src_len,
    input  wire [PORTS*ether_arb_pkg::DATA_W-1:0] src_data,
    output logic [PORTS-1:0]                      src_ack,
    fifo_if.producer                              fifo
);

    localparam int IDX_W = $clog2(PORTS);

    typedef enum logic [1:0] {ST_IDLE, ST_HDR, ST_DATA} state_t;

    state_t                             state;
    logic [ether_arb_pkg::LEN_W-1:0]    word_cnt;   // Data words written so far.
    logic [PORTS-1:0]                   grant;
    logic                               grant_valid;
    logic [IDX_W-1:0]                   grant_idx;
    logic [PORTS-1:0]                   arb_req;
    logic [PORTS-1:0]                   arb_ack;
    logic [ether_arb_pkg::PORT_W-1:0]   grant_port;
    logic [ether_arb_pkg::LEN_W-1:0]    sel_len;
    logic [ether_arb_pkg::DATA_W-1:0]   sel_data;
    logic                               hdr_wr;
    logic                               data_wr;
    logic                               last_wr;

    // Finished source is hidden from the arbiter in its ack cycle.
    assign arb_req = src_req & ~arb_ack;

    arbiter #(
        .PORTS                (PORTS),
        .ARB_TYPE_ROUND_ROBIN (1'b1),
        .ARB_BLOCK            (1'b1),
        .ARB_BLOCK_ACK        (1'b1),
        .ARB_LSB_HIGH_PRIORITY(1'b0)
    ) u_arb (
        .clk          (clk),
        .rst_n        (rst_n),
        .request      (arb_req),
        .acknowledge  (arb_ack),
        .grant        (grant),
        .grant_valid  (grant_valid),
        .grant_encoded(grant_idx)
    );

    assign sel_len  = src_len[grant_idx*ether_arb_pkg::LEN_W +: ether_arb_pkg::LEN_W];
    assign sel_data = src_data[grant_idx*ether_arb_pkg::DATA_W +: ether_arb_pkg::DATA_W];

    assign hdr_wr  = (state == ST_HDR) && !fifo.full;   // Stall under back-pressure.
    assign data_wr = (state == ST_DATA) && !fifo.full;
    assign last_wr = data_wr && (word_cnt == sel_len - 1'b1);

    assign src_ack     = grant & {PORTS{data_wr}};  // Source steps to its next word.
    assign arb_ack     = grant & {PORTS{last_wr}};  // Releases the grant.
    assign fifo.wr_en  = hdr_wr || data_wr;

    always_comb begin
        grant_port               = '0;
        grant_port[IDX_W-1:0]    = grant_idx;  // Zero-extend into the header field.
        fifo.wr_entry            = '0;
        fifo.wr_entry.is_hdr     = (state == ST_HDR);
        if (state == ST_HDR) begin
            fifo.wr_entry.body.hdr.port = grant_port;
            fifo.wr_entry.body.hdr.len  = sel_len;
        end else begin
            fifo.wr_entry.body.data = sel_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Burst sequencing

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            word_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (grant_valid) begin
                        state <= ST_HDR;  // New grant registered.
                    end
                end
                ST_HDR: begin
                    if (hdr_wr) begin
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (last_wr) begin
                        state    <= ST_IDLE;
                        word_cnt <= '0;
                    end else if (data_wr) begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    a_ack_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(src_ack));

endmodule

`default_nettype wire

// ==== ether_arb.f ====
ether_arb_pkg.sv
priority_encoder.sv
arbiter.sv
fifo_if.sv
burst_gather.sv
word_fifo.sv
stream_drain.sv
ether_arb_top.sv
tb_ether_arb.sv

// ==== ether_arb_pkg.sv ====
`default_nettype none

package ether_arb_pkg;

    localparam int DATA_W = 16;  // Data word and union payload width.
    localparam int PORT_W = 4;   // Source index field for up to 16 sources.
    localparam int LEN_W  = 4;   // Burst length field for 1 to 15 words.

    // Header word that leads every burst in the FIFO.
    typedef struct packed {
        logic [PORT_W-1:0] port;      // Granted source.
        logic [LEN_W-1:0]  len;       // Data words that follow.
        logic [7:0]        reserved;  // Always zero.
    } burst_hdr_t;

    // One payload word read either as a header or as data.
    typedef union packed {
        burst_hdr_t        hdr;
        logic [DATA_W-1:0] data;
    } entry_body_u;

    typedef struct packed {
        logic        is_hdr;  // Selects the view of body.
        entry_body_u body;
    } fifo_entry_t;

endpackage

`default_nettype wire

// ==== ether_arb_top.sv ====
`default_nettype none

module ether_arb_top #(
    parameter int PORTS      = 4,
    parameter int FIFO_DEPTH = 8
) (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire [PORTS-1:0]                       src_req,    // Held for the whole burst.
    input  wire [PORTS*ether_arb_pkg::LEN_W-1:0]  src_len,
    input  wire [PORTS*ether_arb_pkg::DATA_W-1:0] src_data,
    output logic [PORTS-1:0]                      src_ack,
    input  wire                                   drain_en,
    output logic                                  out_valid,
    output logic                                  out_is_hdr,
    output logic [ether_arb_pkg::PORT_W-1:0]      out_port,
    output logic [ether_arb_pkg::LEN_W-1:0]       out_len,
    output logic [ether_arb_pkg::DATA_W-1:0]      out_data
);

    fifo_if fifo_bus ();

    ////////////////////////////////////////////////////////////////////////////
    // Producer, buffer and consumer

    burst_gather #(
        .PORTS(PORTS)
    ) u_gather (
        .clk     (clk),
        .rst_n   (rst_n),
        .src_req (src_req),
        .src_len (src_len),
        .src_data(src_data),
        .src_ack (src_ack),
        .fifo    (fifo_bus.producer)
    );

    word_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk  (clk),
        .rst_n(rst_n),
        .fifo (fifo_bus.buffer)
    );

    stream_drain u_drain (
        .clk       (clk),
        .rst_n     (rst_n),
        .fifo      (fifo_bus.consumer),
        .drain_en  (drain_en),
        .out_valid (out_valid),
        .out_is_hdr(out_is_hdr),
        .out_port  (out_port),
        .out_len   (out_len),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

// ==== fifo_if.sv ====
`default_nettype none

interface fifo_if;

    logic                       wr_en;     // Push strobe.
    ether_arb_pkg::fifo_entry_t wr_entry;
    logic                       full;
    logic                       rd_en;     // Pop strobe.
    ether_arb_pkg::fifo_entry_t rd_entry;  // Head entry before the pop.
    logic                       empty;

    modport producer (output wr_en, output wr_entry, input full);
    modport buffer   (input wr_en, input wr_entry, input rd_en,
                      output full, output empty, output rd_entry);
    modport consumer (output rd_en, input rd_entry, input empty);

endinterface

`default_nettype wire

// ==== priority_encoder.sv ====
`default_nettype none

module priority_encoder #(
    parameter int WIDTH             = 4,
    parameter bit LSB_HIGH_PRIORITY = 1'b0
) (
    input  wire [WIDTH-1:0]          input_unencoded,
    output logic                     output_valid,
    output logic [$clog2(WIDTH)-1:0] output_encoded,
    output logic [WIDTH-1:0]         output_unencoded
);

    localparam int LEVELS = $clog2(WIDTH);
    localparam int W      = 2 ** LEVELS;  // Input padded to a power of two.

    logic [W-1:0]        vld [LEVELS+1];     // Per-node valid at each level.
    logic [LEVELS-1:0]   idx [LEVELS+1][W];  // Per-node winning index.

    assign vld[0] = W'(input_unencoded);  // Padding bits never win.

    for (genvar n = 0; n < W; n++) begin : g_leaf
        assign idx[0][n] = '0;
    end

    // Each level halves the node count by pairwise selection.
    for (genvar l = 0; l < LEVELS; l++) begin : g_level
        for (genvar n = 0; n < (W >> (l + 1)); n++) begin : g_node
            logic take_hi;
            assign take_hi = LSB_HIGH_PRIORITY ? !vld[l][2*n] : vld[l][2*n+1];
            assign vld[l+1][n] = vld[l][2*n] | vld[l][2*n+1];
            assign idx[l+1][n] = take_hi ? (idx[l][2*n+1] | LEVELS'(1 << l))
                                         : idx[l][2*n];  // Upper child sets bit l.
        end
    end

    assign output_valid     = vld[LEVELS][0];  // Root of the tree.
    assign output_encoded   = idx[LEVELS][0];
    assign output_unencoded = output_valid ? (WIDTH'(1) << output_encoded) : '0;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line.
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_ether_arb -f ether_arb.f
sim_out="$(./obj_dir/Vtb_ether_arb)"
printf '%s\n' "$sim_out"
if grep -qxF '** PASS **' <<< "$sim_out"; then
    exit 0
fi
exit 1

// ==== stream_drain.sv ====
`default_nettype none

module stream_drain (
    input  wire                               clk,
    input  wire                               rst_n,
    fifo_if.consumer                          fifo,
    input  wire                               drain_en,
    output logic                              out_valid,
    output logic                              out_is_hdr,
    output logic [ether_arb_pkg::PORT_W-1:0]  out_port,
    output logic [ether_arb_pkg::LEN_W-1:0]   out_len,
    output logic [ether_arb_pkg::DATA_W-1:0]  out_data
);

    ether_arb_pkg::fifo_entry_t entry_q;  // Last popped entry.
    ether_arb_pkg::burst_hdr_t  hdr_view;

    assign fifo.rd_en = drain_en && !fifo.empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= fifo.rd_en;  // One pulse per pop.
        end
    end

    always_ff @(posedge clk) begin
        if (fifo.rd_en) begin
            entry_q <= fifo.rd_entry;
        end
    end

    // Union decode by entry kind.
    assign hdr_view   = entry_q.body.hdr;
    assign out_is_hdr = out_valid && entry_q.is_hdr;
    assign out_port   = out_is_hdr ? hdr_view.port : '0;
    assign out_len    = out_is_hdr ? hdr_view.len : '0;
    assign out_data   = (out_valid && !entry_q.is_hdr) ? entry_q.body.data : '0;

    // Producer never emits an empty burst.
    a_hdr_len: assert property (@(posedge clk) disable iff (!rst_n)
        (fifo.rd_en && fifo.rd_entry.is_hdr) |-> (fifo.rd_entry.body.hdr.len != '0));

endmodule

`default_nettype wire

// ==== tb_ether_arb.sv ====
`default_nettype none

module tb_ether_arb;

    localparam int PORTS       = 4;
    localparam int FIFO_DEPTH  = 8;
    localparam int DATA_W      = ether_arb_pkg::DATA_W;
    localparam int PORT_W      = ether_arb_pkg::PORT_W;
    localparam int LEN_W       = ether_arb_pkg::LEN_W;
    localparam int CYCLE_LIMIT = 4000;  // About 680 burst words at 4 cycles each, plus margin.

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic [PORTS-1:0]           src_req;
    logic [PORTS*LEN_W-1:0]     src_len;
    logic [PORTS*DATA_W-1:0]    src_data;
    logic [PORTS-1:0]           src_ack;
    logic                       drain_en;
    logic                       out_valid;
    logic                       out_is_hdr;
    logic [PORT_W-1:0]          out_port;
    logic [LEN_W-1:0]           out_len;
    logic [DATA_W-1:0]          out_data;

    int                         words_left [PORTS];  // Words the source still owes.
    logic [LEN_W-1:0]           burst_len  [PORTS];
    logic [7:0]                 seq        [PORTS];  // Low byte of the current word.
    logic [PORTS-1:0]           ack_pend;            // Acks taken at the next rising edge.
    int                         ack_total;
    int                         last_port;           // Last predicted winner.
    ether_arb_pkg::fifo_entry_t ref_q [$];           // Expected entries in output order.
    logic [31:0]                rng_state;
    int                         cycle_count;
    int                         error_count;
    int                         check_total;

    always #10 clk = ~clk;

    ether_arb_top #(
        .PORTS     (PORTS),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .src_req   (src_req),
        .src_len   (src_len),
        .src_data  (src_data),
        .src_ack   (src_ack),
        .drain_en  (drain_en),
        .out_valid (out_valid),
        .out_is_hdr(out_is_hdr),
        .out_port  (out_port),
        .out_len   (out_len),
        .out_data  (out_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks and source models

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_hdr(input ether_arb_pkg::burst_hdr_t exp);
        check_total++;
        if (out_port !== exp.port) begin
            error_count++;
            $display("[FAIL] %0t out_port exp %0d got %0d", $time, exp.port, out_port);
        end
        if (out_len !== exp.len) begin
            error_count++;
            $display("[FAIL] %0t out_len exp %0d got %0d", $time, exp.len, out_len);
        end
        if (out_data !== '0) begin
            error_count++;  // Data field is unused on a header.
            $display("[FAIL] %0t out_data exp %h got %h", $time, DATA_W'(0), out_data);
        end
    endtask

    task automatic check_data(input logic [DATA_W-1:0] exp);
        check_total++;
        if (out_data !== exp) begin
            error_count++;
            $display("[FAIL] %0t out_data exp %h got %h", $time, exp, out_data);
        end
        if (out_port !== '0) begin
            error_count++;  // Header fields are unused on data.
            $display("[FAIL] %0t out_port exp 0 got %0d", $time, out_port);
        end
        if (out_len !== '0) begin
            error_count++;
            $display("[FAIL] %0t out_len exp 0 got %0d", $time, out_len);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int got);
        check_total++;
        if (got != exp) begin
            error_count++;
            $display("[FAIL] %0t %s exp %0d got %0d", $time, name, exp, got);
        end
    endtask

    task automatic match_output();
        ether_arb_pkg::fifo_entry_t exp;
        if (ref_q.size() == 0) begin
            error_count++;
            $display("Output entry at %0t while no entry was expected.", $time);
        end else begin
            exp = ref_q.pop_front();
            if (out_is_hdr !== exp.is_hdr) begin
                error_count++;
                $display("[FAIL] %0t out_is_hdr exp %0b got %0b", $time, exp.is_hdr, out_is_hdr);
            end else if (exp.is_hdr) begin
                check_hdr(exp.body.hdr);  // Header view of the union.
            end else begin
                check_data(exp.body.data);
            end
        end
    endtask

    task automatic drive_sources();
        for (int p = 0; p < PORTS; p++) begin
            src_req[p]                   = (words_left[p] != 0);  // Held to the last ack.
            src_len[p*LEN_W +: LEN_W]    = burst_len[p];
            src_data[p*DATA_W +: DATA_W] = {8'(p), seq[p]};       // Index * 256 + sequence.
        end
    endtask

    // Checks outputs, steps the sources and drives inputs on one falling edge.
    task automatic tick();
        @(negedge clk);
        cycle_count++;
        if (out_valid) begin
            match_output();
        end
        for (int p = 0; p < PORTS; p++) begin
            if (ack_pend[p]) begin
                seq[p]        = seq[p] + 8'd1;  // Word went in on the rising edge.
                words_left[p] = words_left[p] - 1;
                ack_total++;
            end
            if (src_ack[p] === 1'b1 && words_left[p] == 0) begin
                error_count++;
                $display("src_ack pulsed for idle source %0d at %0t.", p, $time);
            end
        end
        ack_pend = src_ack;
        drive_sources();
    endtask

    // Queues the expected header and words, in predicted grant order.
    task automatic start_burst(input int port, input int len);
        ether_arb_pkg::fifo_entry_t entry;
        entry               = '0;
        entry.is_hdr        = 1'b1;
        entry.body.hdr.port = PORT_W'(port);
        entry.body.hdr.len  = LEN_W'(len);
        ref_q.push_back(entry);
        for (int k = 0; k < len; k++) begin
            entry           = '0;
            entry.body.data = {8'(port), seq[port] + 8'(k)};
            ref_q.push_back(entry);
        end
        burst_len[port]  = LEN_W'(len);
        words_left[port] = len;
        last_port        = port;
        drive_sources();
    endtask

    function automatic int words_pending();
        int sum;
        sum = 0;
        for (int p = 0; p < PORTS; p++) begin
            sum += words_left[p];
        end
        return sum;
    endfunction

    task automatic settle();
        int spare;
        spare = FIFO_DEPTH + 4;  // A full FIFO drains one entry per cycle.
        while (words_pending() != 0) begin
            tick();
        end
        while (ref_q.size() != 0 && spare > 0) begin
            tick();
            spare--;
        end
        check_count("reference queue size", 0, ref_q.size());
        ref_q.delete();
        repeat (4) tick();  // Room for a stray entry to show up.
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic quiet_after_reset();
        drain_en = 1'b1;
        repeat (10) begin
            tick();
            check_count("src_ack", 0, int'(src_ack));
            check_count("out_valid", 0, int'(out_valid));
        end
    endtask

    task automatic all_ports_rotation();
        int first;
        repeat (2) begin
            first = last_port;
            for (int k = 1; k <= PORTS; k++) begin
                start_burst((first - k + PORTS) % PORTS, 2);  // Next one below the last winner.
            end
            settle();
        end
    endtask

    task automatic single_burst();
        start_burst(2, 5);
        settle();
    endtask

    task automatic back_pressure();
        int acks_before;
        drain_en    = 1'b0;
        acks_before = ack_total;
        start_burst(1, 12);
        repeat (30) tick();
        check_count("src_ack words before drain", FIFO_DEPTH - 1, ack_total - acks_before);
        drain_en = 1'b1;
        settle();
    endtask

    task automatic random_traffic();
        int port;
        int len;
        repeat (40) begin
            port = int'(next_random() % PORTS);
            len  = int'(next_random() % 32'd15) + 1;
            start_burst(port, len);
            while (words_pending() != 0) begin
                tick();
                drain_en = (next_random() % 32'd4) != 32'd0;  // Gaps on one cycle in four.
            end
        end
        drain_en = 1'b1;
        settle();
    endtask

    initial begin
        rst_n       = 1'b0;
        src_req     = '0;
        src_len     = '0;
        src_data    = '0;
        drain_en    = 1'b0;
        ack_pend    = '0;
        ack_total   = 0;
        last_port   = 0;  // Reset mask starts at the top index.
        rng_state   = 32'h561e;
        cycle_count = 0;
        error_count = 0;
        check_total = 0;
        for (int p = 0; p < PORTS; p++) begin
            words_left[p] = 0;
            burst_len[p]  = '0;
            seq[p]        = '0;
        end
        repeat (5) tick();
        rst_n = 1'b1;
        quiet_after_reset();
        all_ports_rotation();
        single_burst();
        back_pressure();
        random_traffic();
        $display("Checks: %0d  errors: %0d", check_total, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        wait (cycle_count >= CYCLE_LIMIT);
        $display("Timeout: the tests did not finish within %0d cycles.", CYCLE_LIMIT);
        $display("Checks: %0d  errors: %0d", check_total, error_count);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== word_fifo.sv ====
`default_nettype none

module word_fifo #(
    parameter int FIFO_DEPTH = 8  // Power of two.
) (
    input  wire     clk,
    input  wire     rst_n,
    fifo_if.buffer  fifo
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    ether_arb_pkg::fifo_entry_t mem [FIFO_DEPTH];  // Ring storage.
    logic [ADDR_W:0]            wr_ptr;             // Extra bit tells full from empty.
    logic [ADDR_W:0]            rd_ptr;
    logic                       do_wr;
    logic                       do_rd;

    assign do_wr = fifo.wr_en && !fifo.full;
    assign do_rd = fifo.rd_en && !fifo.empty;

    assign fifo.empty    = (wr_ptr == rd_ptr);
    assign fifo.full     = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                           (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);  // Wrapped once.
    assign fifo.rd_entry = mem[rd_ptr[ADDR_W-1:0]];  // Head shown before the pop.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr[ADDR_W-1:0]] <= fifo.wr_entry;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        fifo.wr_en |-> !fifo.full);

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        fifo.rd_en |-> !fifo.empty);

endmodule

`default_nettype wire
